// File: all.f
+incdir+hdl
hdl/isa_pkg.sv
hdl/icache_pkg.sv
hdl/icache.sv
hdl/fetch_unit.sv
hdl/if_id_reg.sv
hdl/decode_stage.sv
hdl/proc_front.sv
tests/tb_clock.sv
tests/tb_proc_front.sv

// File: hdl/decode_stage.sv
// Instruction decode stage
`timescale 1ns/10ps
`include "proc_consts.svh"

module decode_stage (
  input  logic                    clk,        // System clock
  input  logic                    rst,        // Synchronous reset, active high
  input  icache_pkg::fetch_word_t id_fw,      // Word from IF/ID
  input  logic                    id_valid,   // IF/ID slot live
  output isa_pkg::decoded_t       dec,        // Decoded fields
  output logic                    dec_valid,  // dec holds a new instruction
  output logic                    hlt         // Sticky once HLT is decoded
);

  logic [`PROC_OPCODE_W-1:0] opcode;  // Top nibble
  isa_pkg::op_class_t        op_class;
  logic                      take;    // Accept this word

  assign opcode = id_fw.inst[`PROC_WORD_W-1 -: `PROC_OPCODE_W];
  assign take   = id_valid & ~hlt;    // Nothing passes after HLT

  ////////////////////////////////////////
  // Opcode class
  ////////////////////////////////////////
  always_comb begin
    case (opcode)
      4'h8:       op_class = isa_pkg::OPC_LOAD;
      4'h9:       op_class = isa_pkg::OPC_STORE;
      4'hA, 4'hB: op_class = isa_pkg::OPC_LOAD_BYTE;  // LLB, LHB
      4'hC, 4'hD: op_class = isa_pkg::OPC_BRANCH;     // B, BR
      4'hE:       op_class = isa_pkg::OPC_PCS;
      4'hF:       op_class = isa_pkg::OPC_HLT;
      default:    op_class = isa_pkg::OPC_ALU;        // 0 through 7
    endcase
  end

  // Control
  always_ff @(posedge clk) begin
    if (rst) begin
      dec_valid <= 1'b0;
      hlt       <= 1'b0;
    end else begin
      dec_valid <= take;
      hlt       <= hlt | (take & id_fw.is_hlt);  // Rises with the HLT's dec_valid
    end
  end

  // Field slicing of the payload
  always_ff @(posedge clk) begin
    if (take) begin
      dec.op_class <= op_class;
      dec.rd       <= id_fw.inst[11:8];
      dec.rs       <= id_fw.inst[7:4];
      dec.rt       <= id_fw.inst[3:0];
      dec.imm      <= id_fw.inst[7:0];  // Low byte for LLB/LHB style immediates
      dec.pc       <= id_fw.pc;
    end
  end

  // Fetch has stopped by the time hlt is high, so no word reaches decode
  a_quiet_after_hlt: assert property (@(posedge clk) disable iff (rst)
    hlt |-> !id_valid);

endmodule

// File: hdl/fetch_unit.sv
// Program counter and instruction fetch
`timescale 1ns/10ps
`include "proc_consts.svh"

module fetch_unit (
  input  logic                    clk,             // System clock
  input  logic                    rst,             // Synchronous reset, active high
  input  isa_pkg::word_t          mem_data_in,     // Off-chip read data
  input  logic                    mem_data_valid,  // Off-chip data strobe
  output logic                    mem_en,          // Off-chip request
  output isa_pkg::addr_t          mem_addr,        // Off-chip word address
  output icache_pkg::fetch_word_t fw,              // Word, pc and halt flag
  output logic                    fw_valid,        // High on every hit
  output isa_pkg::addr_t          pc               // Current fetch address
);

  logic           req;     // Fetch request that drops once halted
  logic           hit;     // Cache hit on pc
  logic           halted;  // HLT captured and fetch frozen
  isa_pkg::word_t inst;    // Cache read data

  assign req = ~halted;

  icache u_icache (
    .clk           (clk),
    .rst           (rst),
    .req           (req),
    .pc            (pc),
    .mem_data_in   (mem_data_in),
    .mem_data_valid(mem_data_valid),
    .hit           (hit),
    .inst          (inst),
    .mem_en        (mem_en),
    .mem_addr      (mem_addr)
  );

  ////////////////////////////////////////
  // Fetched word to IF/ID
  ////////////////////////////////////////
  assign fw_valid  = req & hit;
  assign fw.inst   = inst;
  assign fw.pc     = pc;
  assign fw.is_hlt = (inst[`PROC_WORD_W-1 -: `PROC_OPCODE_W] == '1);  // Opcode F

  // Sequential PC that advances only on a hit
  always_ff @(posedge clk) begin
    if (rst) begin
      pc     <= '0;
      halted <= 1'b0;
    end else if (fw_valid) begin
      pc <= pc + isa_pkg::addr_t'(`PROC_PC_STEP);
      if (fw.is_hlt) begin
        halted <= 1'b1;  // Sticky until reset
      end
    end
  end

  // No off-chip request once HLT is captured
  a_no_mem_after_hlt: assert property (@(posedge clk) disable iff (rst)
    halted |-> !mem_en);

endmodule

// File: hdl/icache.sv
// Direct-mapped instruction cache
`timescale 1ns/10ps
`include "proc_consts.svh"

module icache (
  input  logic           clk,             // System clock
  input  logic           rst,             // Synchronous reset, active high
  input  logic           req,             // Fetch request for pc
  input  isa_pkg::addr_t pc,              // Fetch address
  input  isa_pkg::word_t mem_data_in,     // Off-chip read data
  input  logic           mem_data_valid,  // Off-chip data strobe
  output logic           hit,             // pc present in cache
  output isa_pkg::word_t inst,            // Word at pc when hit is high
  output logic           mem_en,          // Held high during a line fill
  output isa_pkg::addr_t mem_addr         // Word address being filled
);

  ////////////////////////////////////////
  // Storage and fill state
  ////////////////////////////////////////
  icache_pkg::tag_t    pc_tag;      // Fields of the fetch address
  icache_pkg::index_t  pc_index;
  icache_pkg::offset_t pc_offset;

  isa_pkg::word_t          data_arr [`ICACHE_SETS][`ICACHE_WORDS_PER_LINE];
  icache_pkg::tag_t        tag_arr  [`ICACHE_SETS];
  logic [`ICACHE_SETS-1:0] valid_arr;  // One valid bit per line

  logic                filling;     // Line fill in progress
  icache_pkg::offset_t fill_cnt;    // Next word of the line to request
  icache_pkg::tag_t    fill_tag;    // Line under fill
  icache_pkg::index_t  fill_index;
  logic                miss;        // Requested and absent with no fill running
  logic                fill_wr;     // Word returned this cycle
  logic                fill_last;   // Current word closes the line

  // Bit 0 is the byte select and stays zero on fetch
  assign {pc_tag, pc_index, pc_offset} = pc[`PROC_WORD_W-1:1];

  ////////////////////////////////////////
  // Lookup
  ////////////////////////////////////////
  assign hit  = req & valid_arr[pc_index] & (tag_arr[pc_index] == pc_tag);
  assign inst = data_arr[pc_index][pc_offset];  // Read regardless of hit
  assign miss = req & ~hit & ~filling;

  // Off-chip request follows the fill counter
  assign mem_en    = filling;
  assign mem_addr  = {fill_tag, fill_index, fill_cnt, 1'b0};
  assign fill_wr   = filling & mem_data_valid;  // Strobe outside a fill is ignored
  assign fill_last = (fill_cnt == icache_pkg::offset_t'(`ICACHE_WORDS_PER_LINE - 1));

  ////////////////////////////////////////
  // Fill control
  ////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (rst) begin
      filling   <= 1'b0;
      fill_cnt  <= '0;
      valid_arr <= '0;                   // Every line invalid
    end else if (miss) begin
      filling  <= 1'b1;                  // mem_en rises next cycle
      fill_cnt <= '0;                    // Always start at word 0
    end else if (fill_wr) begin
      fill_cnt <= fill_cnt + 1'b1;       // Wraps to 0 after the last word
      valid_arr[fill_index] <= fill_last;  // Cleared on early words and set on the last
      if (fill_last) begin
        filling <= 1'b0;                 // pc hits in the following cycle
      end
    end
  end

  // Line address and data
  always_ff @(posedge clk) begin
    if (miss) begin
      fill_tag   <= pc_tag;
      fill_index <= pc_index;
    end
    if (fill_wr) begin
      data_arr[fill_index][fill_cnt] <= mem_data_in;
      tag_arr[fill_index]            <= fill_tag;
    end
  end

  ////////////////////////////////////////
  // Checks
  ////////////////////////////////////////
  // Off-chip request held until the memory answers
  a_mem_hold: assert property (@(posedge clk) disable iff (rst)
    (mem_en && !mem_data_valid) |=> (mem_en && $stable(mem_addr)));

  // Partially written line must never be served
  a_no_hit_in_fill: assert property (@(posedge clk) disable iff (rst)
    filling |-> !hit);

endmodule

// File: hdl/icache_pkg.sv
// Instruction cache types
`include "proc_consts.svh"

package icache_pkg;

  ////////////////////////////////////////
  // Address fields
  ////////////////////////////////////////
  // Byte address split as {tag, index, offset, byte bit}
  typedef logic [`ICACHE_TAG_W-1:0]    tag_t;
  typedef logic [`ICACHE_INDEX_W-1:0]  index_t;
  typedef logic [`ICACHE_OFFSET_W-1:0] offset_t;

  ////////////////////////////////////////
  // Fetched word
  ////////////////////////////////////////
  // Passed from fetch through IF/ID into decode
  typedef struct packed {
    isa_pkg::word_t inst;    // Raw instruction word
    isa_pkg::addr_t pc;      // PC it was fetched from
    logic           is_hlt;  // Opcode is F
  } fetch_word_t;

  // Width check helper for the line buffer
  typedef logic [`ICACHE_WORDS_PER_LINE-1:0] word_mask_t;

endpackage

// File: hdl/if_id_reg.sv
// IF/ID pipeline register
`timescale 1ns/10ps

module if_id_reg (
  input  logic                    clk,       // System clock
  input  logic                    rst,       // Synchronous reset, active high
  input  icache_pkg::fetch_word_t fw,        // Word from fetch
  input  logic                    fw_valid,  // Fetch strobe
  output icache_pkg::fetch_word_t id_fw,     // Word for decode
  output logic                    id_valid   // Slot holds a live word
);

  ////////////////////////////////////////
  // Valid bit
  ////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (rst) begin
      id_valid <= 1'b0;      // Flush the slot
    end else begin
      id_valid <= fw_valid;  // Bubble on a miss cycle
    end
  end

  // Payload held through bubbles
  always_ff @(posedge clk) begin
    if (fw_valid) begin
      id_fw <= fw;
    end
  end

endmodule

// File: hdl/isa_pkg.sv
// Instruction set types
`include "proc_consts.svh"

package isa_pkg;

  typedef logic [`PROC_WORD_W-1:0]   word_t;    // Instruction or data word
  typedef logic [`PROC_WORD_W-1:0]   addr_t;    // Byte address
  typedef logic [`PROC_REG_ID_W-1:0] reg_id_t;  // Register file index

  ////////////////////////////////////////
  // Opcode classes
  ////////////////////////////////////////
  // 0-7 ALU, 8 LW, 9 SW, A-B LLB/LHB, C-D B/BR, E PCS, F HLT
  typedef enum logic [2:0] {
    OPC_ALU,
    OPC_LOAD,
    OPC_STORE,
    OPC_LOAD_BYTE,
    OPC_BRANCH,
    OPC_PCS,
    OPC_HLT
  } op_class_t;

  // Decoded instruction as it leaves the front end
  typedef struct packed {
    op_class_t  op_class;  // Class from the opcode nibble
    reg_id_t    rd;        // Bits 11:8
    reg_id_t    rs;        // Bits 7:4
    reg_id_t    rt;        // Bits 3:0
    logic [7:0] imm;       // Low byte
    addr_t      pc;        // Address the word was fetched from
  } decoded_t;

endpackage

// File: hdl/proc_consts.svh
// Front end widths and cache geometry
`ifndef PROC_CONSTS_SVH
`define PROC_CONSTS_SVH

////////////////////////////////////////
// Datapath widths
////////////////////////////////////////
`define PROC_WORD_W   16  // Data word and byte address width
`define PROC_REG_ID_W 4   // Register id, 16 registers
`define PROC_OPCODE_W 4   // Top nibble of the instruction word

// Byte addressed, one 16-bit word per step
`define PROC_PC_STEP  2

////////////////////////////////////////
// Instruction cache geometry
////////////////////////////////////////
`define ICACHE_SETS           8   // Direct mapped, one line per set
`define ICACHE_WORDS_PER_LINE 4   // Words filled per miss
`define ICACHE_OFFSET_W       2   // Word offset within a line
`define ICACHE_INDEX_W        3   // log2 of ICACHE_SETS
`define ICACHE_TAG_W          10  // 16 - index - offset - byte bit

`endif

// File: hdl/proc_front.sv
// Instruction front end top level
`timescale 1ns/10ps

module proc_front (
  input  logic              clk,             // System clock
  input  logic              rst,             // Synchronous reset, active high
  input  isa_pkg::word_t    mem_data_in,     // Off-chip read data
  input  logic              mem_data_valid,  // Off-chip data strobe
  output logic              mem_en,          // Off-chip request
  output isa_pkg::addr_t    mem_addr,        // Off-chip word address
  output isa_pkg::addr_t    pc,              // Fetch PC
  output isa_pkg::decoded_t dec,             // Decoded instruction
  output logic              dec_valid,       // dec is new this cycle
  output logic              hlt              // HLT decoded
);

  ////////////////////////////////////////
  // Stage links
  ////////////////////////////////////////
  icache_pkg::fetch_word_t fw;        // Fetch to IF/ID
  logic                    fw_valid;
  icache_pkg::fetch_word_t id_fw;     // IF/ID to decode
  logic                    id_valid;

  fetch_unit u_fetch (
    .clk           (clk),
    .rst           (rst),
    .mem_data_in   (mem_data_in),
    .mem_data_valid(mem_data_valid),
    .mem_en        (mem_en),
    .mem_addr      (mem_addr),
    .fw            (fw),
    .fw_valid      (fw_valid),
    .pc            (pc)
  );

  if_id_reg u_if_id (
    .clk     (clk),
    .rst     (rst),
    .fw      (fw),
    .fw_valid(fw_valid),
    .id_fw   (id_fw),
    .id_valid(id_valid)
  );

  // Two cycles from hit to dec_valid
  decode_stage u_decode (
    .clk      (clk),
    .rst      (rst),
    .id_fw    (id_fw),
    .id_valid (id_valid),
    .dec      (dec),
    .dec_valid(dec_valid),
    .hlt      (hlt)
  );

endmodule

// File: run.sh
#!/usr/bin/env bash
# Build and run the front end testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f all.f --top-module tb_proc_front -o tb_proc_front &&
./obj_dir/tb_proc_front | tee /dev/stderr | grep -q "^TEST PASS$" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

// File: tests/tb_clock.sv
// Testbench clock and reset
`timescale 1ns/10ps

module tb_clock (
  input  logic rst_req,  // One-cycle pulse restarts reset
  output logic clk,
  output logic rst
);

  localparam int HALF_NS = 20;  // 40 ns period

  logic clk_r    = 1'b0;
  logic rst_r    = 1'b1;        // High from time zero
  int   rst_left = 2;           // Reset edges still owed after the first

  assign clk = clk_r;
  assign rst = rst_r;

  always #HALF_NS clk_r = ~clk_r;

  // rst moves 5 ns after the edge, three edges per reset
  always @(posedge clk_r) begin
    if (rst_req) begin
      rst_left = 3;
    end
    #5;
    rst_r = (rst_left != 0);
    if (rst_left != 0) begin
      rst_left = rst_left - 1;
    end
  end

endmodule

// File: tests/tb_proc_front.sv
// Front end directed testbench
`timescale 1ns/10ps
`include "proc_consts.svh"

module tb_proc_front;

  localparam int PERIOD_NS = 40;
  localparam int IMG_WORDS = 32768;                       // Whole byte space in words
  localparam int WD_CYCLES = (1 + 4 + 21 + 12 + 2 * 12) * 40;  // Instructions per run times 40

  logic              clk;
  logic              rst;
  logic              rst_req        = 1'b0;
  isa_pkg::word_t    mem_data_in    = '0;
  logic              mem_data_valid = 1'b0;
  logic              mem_en;
  isa_pkg::addr_t    mem_addr;
  isa_pkg::addr_t    pc;
  isa_pkg::decoded_t dec;
  logic              dec_valid;
  logic              hlt;

  isa_pkg::word_t    image [IMG_WORDS];  // Off-chip memory
  isa_pkg::word_t    prog [$];           // Program from address 0 with HLT last
  isa_pkg::addr_t    fill_q [$];         // mem_addr at each mem_data_valid
  isa_pkg::decoded_t dec_q [$];
  isa_pkg::decoded_t ref_q [$];
  logic              hlt_q [$];          // hlt beside each dec_valid
  int                dec_cyc_q [$];      // Cycle of each dec_valid
  isa_pkg::addr_t    pc_hist [$];        // pc of every cycle since reset
  int seed      = 41;
  int fixed_lat = 1;                     // 0 draws 1 to 5 cycles
  int lat_left  = -1;
  int test_err  = 0;
  int err_cnt   = 0;
  int test_cnt  = 0;

  tb_clock u_clock (.rst_req(rst_req), .clk(clk), .rst(rst));

  proc_front u_proc_front (
    .clk(clk), .rst(rst), .mem_data_in(mem_data_in), .mem_data_valid(mem_data_valid),
    .mem_en(mem_en), .mem_addr(mem_addr), .pc(pc), .dec(dec), .dec_valid(dec_valid), .hlt(hlt)
  );

  ////////////////////////////////////////
  // Memory model and monitor
  ////////////////////////////////////////
  always @(posedge clk) begin
    #5;
    mem_data_valid = 1'b0;               // Strobe lasts one cycle
    if (rst || !mem_en) begin
      lat_left = -1;
    end else begin
      if (lat_left < 0) begin            // New word requested
        lat_left = (fixed_lat != 0) ? fixed_lat : 1 + ($unsigned($random(seed)) % 5);
      end
      lat_left = lat_left - 1;
      if (lat_left == 0) begin
        mem_data_valid = 1'b1;
        mem_data_in    = image[mem_addr[15:1]];
        fill_q.push_back(mem_addr);
        lat_left = -1;
      end
    end
  end

  // Mid-cycle sampling of settled outputs
  always @(negedge clk) begin
    if (!rst) begin
      pc_hist.push_back(pc);
      if (dec_valid) begin
        dec_q.push_back(dec);
        hlt_q.push_back(hlt);
        dec_cyc_q.push_back(pc_hist.size() - 1);
      end
    end
  end

  ////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////
  task automatic report_problem(input string msg);
    $display("%s", msg);
    test_err++;
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (exp !== act) report_problem($sformatf("ERR %s expected %h actual %h", name, exp, act));
  endtask

  task automatic check_word(input string name, input isa_pkg::word_t exp,
                            input isa_pkg::word_t act);
    if (exp !== act) report_problem($sformatf("ERR %s expected %h actual %h", name, exp, act));
  endtask

  task automatic check_addr(input string name, input isa_pkg::addr_t exp,
                            input isa_pkg::addr_t act);
    if (exp !== act) report_problem($sformatf("ERR %s expected %h actual %h", name, exp, act));
  endtask

  task automatic check_decoded(input string name, input isa_pkg::decoded_t exp,
                               input isa_pkg::decoded_t act);
    if (exp !== act) report_problem($sformatf("ERR %s expected %h actual %h", name, exp, act));
  endtask

  // Opcode ranges of the ISA
  function automatic isa_pkg::decoded_t expect_dec(isa_pkg::word_t w, isa_pkg::addr_t p);
    isa_pkg::decoded_t d;
    logic [3:0] op;
    op = w[15:12];
    if (op <= 4'h7) d.op_class = isa_pkg::OPC_ALU;
    else if (op == 4'h8) d.op_class = isa_pkg::OPC_LOAD;
    else if (op == 4'h9) d.op_class = isa_pkg::OPC_STORE;
    else if (op <= 4'hB) d.op_class = isa_pkg::OPC_LOAD_BYTE;
    else if (op <= 4'hD) d.op_class = isa_pkg::OPC_BRANCH;
    else if (op == 4'hE) d.op_class = isa_pkg::OPC_PCS;
    else d.op_class = isa_pkg::OPC_HLT;
    d.rd  = w[11:8];
    d.rs  = w[7:4];
    d.rt  = w[3:0];
    d.imm = w[7:0];
    d.pc  = p;
    return d;
  endfunction

  ////////////////////////////////////////
  // Run helpers
  ////////////////////////////////////////
  task automatic do_reset();
    int i;
    for (i = 0; i < IMG_WORDS; i++) image[i] = {1'b0, i[14:0]};  // ALU filler
    for (i = 0; i < prog.size(); i++) image[i] = prog[i];
    @(posedge clk);
    #5;
    rst_req = 1'b1;
    @(posedge clk);
    #5;
    rst_req = 1'b0;
    @(negedge clk);                      // rst surely high here
    fill_q.delete();
    dec_q.delete();
    hlt_q.delete();
    dec_cyc_q.delete();
    pc_hist.delete();
    while (rst) @(negedge clk);          // Returns in the first cycle out of reset
  endtask

  task automatic make_prog(input int n);
    int i;
    isa_pkg::word_t w;
    prog.delete();
    for (i = 0; i < n; i++) begin
      w = isa_pkg::word_t'($random(seed));
      w[15:12] = 4'($unsigned($random(seed)) % 15);  // Opcodes 0 to E
      prog.push_back(w);
    end
    prog.push_back(16'hF000 | isa_pkg::word_t'(n));
  endtask

  task automatic finish_test(input string name);
    if (test_err == 0) $display("%s: ok", name);
    else $display("%s: %0d errors", name, test_err);
    err_cnt += test_err;
    test_err = 0;
    test_cnt++;
  endtask

  // Whole program to HLT with stream, halt, two-cycle path and fill order checks
  task automatic run_prog(input string name, input int lat);
    int i;
    int n;
    int d;
    isa_pkg::addr_t p;
    fixed_lat = lat;
    do_reset();
    n = prog.size();
    while (!hlt) @(negedge clk);
    repeat (8) @(negedge clk);           // Quiet period after HLT
    if (dec_q.size() != n) begin
      report_problem($sformatf("%s decoded %0d words instead of %0d", name, dec_q.size(), n));
    end else begin
      for (i = 0; i < n; i++) begin
        p = isa_pkg::addr_t'(i * `PROC_PC_STEP);
        d = dec_cyc_q[i];
        check_decoded("dec", expect_dec(prog[i], p), dec_q[i]);
        check_word("dec.rd_rs_rt", prog[i] & 16'h0FFF,
                   {4'h0, dec_q[i].rd, dec_q[i].rs, dec_q[i].rt});
        check_bit("hlt", (i == n - 1), hlt_q[i]);
        check_addr("pc at hit", p, pc_hist[d - 2]);
        check_addr("pc after hit", p + isa_pkg::addr_t'(`PROC_PC_STEP), pc_hist[d - 1]);
      end
    end
    check_addr("pc", isa_pkg::addr_t'(n * `PROC_PC_STEP), pc);  // Frozen past HLT
    check_bit("mem_en", 1'b0, mem_en);
    if (fill_q.size() != ((n + 3) / 4) * `ICACHE_WORDS_PER_LINE) begin
      report_problem($sformatf("%s saw %0d fill words, not whole lines", name, fill_q.size()));
    end else begin
      for (i = 0; i < fill_q.size(); i++) begin
        check_addr("mem_addr", isa_pkg::addr_t'(i * 2), fill_q[i]);
      end
    end
    finish_test(name);
  endtask

  ////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////
  task automatic test_reset();
    prog.delete();
    prog.push_back(16'hF000);
    do_reset();
    check_addr("pc", 16'h0000, pc);
    check_bit("mem_en", 1'b0, mem_en);
    check_bit("dec_valid", 1'b0, dec_valid);
    check_bit("hlt", 1'b0, hlt);
    finish_test("reset_state");
  endtask

  task automatic test_fill();
    prog.delete();
    prog.push_back(16'h1123);
    prog.push_back(16'h2456);
    prog.push_back(16'h3789);
    prog.push_back(16'hF000);            // HLT in the last word of line 0
    run_prog("line_fill", 0);
  endtask

  task automatic test_latency();
    int i;
    make_prog(11);
    run_prog("latency_fixed", 1);
    ref_q = dec_q;
    run_prog("latency_random", 0);
    if (ref_q.size() != dec_q.size()) report_problem("decode streams differ in length");
    else for (i = 0; i < ref_q.size(); i++) check_decoded("dec", ref_q[i], dec_q[i]);
    finish_test("latency_match");
  endtask

  initial begin
    test_fill();
    test_reset();                        // Starts from a halted core with pc and hlt set
    make_prog(20);                       // HLT at word 0 of line 5
    run_prog("decode_fields", 0);
    make_prog(11);                       // HLT at the end of line 2
    run_prog("halt_line_end", 0);
    test_latency();
    $display("%0d tests, %0d errors", test_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(WD_CYCLES * PERIOD_NS);
    $display("Run did not finish within %0d cycles", WD_CYCLES);
    $display("TEST FAIL");
    $finish;
  end

endmodule
